/* hdl/mr_defines.svh */
/*
 * sizes for the grid maze router
 * grid side and coordinate width, net list depth, cost width
 */

`ifndef MR_DEFINES_SVH
`define MR_DEFINES_SVH

// coordinate width, one side of the grid is 2**bits cells
`define MR_GRID_BITS 4

// cells per side, also map row width and row count
`define MR_GRID_SIZE 16

// nets held per job
`define MR_NET_MAX 15

// path cost accumulator
`define MR_COST_BITS 14

`endif

/* hdl/mr_pkg.sv */
/*
 * maze router types
 * cell codes, controller states, coordinate, net and neighbor structs
 */

`include "mr_defines.svh"

`default_nettype none

package mr_pkg;

	// upper bit set marks a cell reached by the wavefront
	typedef enum logic [1:0] {
		cell_empty   = 2'd0,
		cell_blocked = 2'd1,
		cell_two     = 2'd2,
		cell_three   = 2'd3
	} cell_t;

	typedef enum logic [3:0] {
		st_idle,
		st_load,
		st_init,
		st_propagate,
		st_retrace,
		st_clean
	} route_state_t;

	typedef struct packed {
		logic [`MR_GRID_BITS-1:0] x;
		logic [`MR_GRID_BITS-1:0] y;
	} coord_t;

	typedef struct packed {
		coord_t src;
		coord_t sink;
	} net_t;

	// cells around the retrace position, off-grid reads as blocked
	typedef struct packed {
		cell_t down;
		cell_t up;
		cell_t right;
		cell_t left;
	} neighbors_t;

endpackage

`default_nettype wire

/* hdl/route_ctrl.sv */
/*
 * routing FSM
 * per-net init, propagate, retrace and clean sequencing,
 * 2-2-3-3 wavefront code counter and busy flag
 */

`default_nettype none

module route_ctrl (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          in_valid,
	input  logic          sink_reached,
	input  logic          arrived,
	input  logic          last_net,
	output logic          seed,
	output logic          propagate,
	output logic          block_en,
	output logic          clean,
	output logic          trace_start,
	output logic          trace_step,
	output logic          next_net,
	output logic          job_start,
	output logic          busy,
	output mr_pkg::cell_t seq_code
);
	import mr_pkg::*;

	route_state_t state;
	route_state_t next_state;

	// index into the 2,2,3,3 code sequence
	logic [1:0] seq_cnt;

	// ======================================================================
	// state machine
	// ======================================================================

	// reset lands in clean so the grid row counter starts from zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_clean;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle:      if (in_valid) next_state = st_load;
			st_load:      if (!in_valid) next_state = st_init;
			st_init:      next_state = st_propagate;
			st_propagate: if (sink_reached) next_state = st_retrace;
			st_retrace:   if (arrived) next_state = st_clean;
			st_clean:     next_state = last_net ? st_idle : st_init;
			default:      next_state = st_idle;
		endcase
	end

	assign job_start   = (state == st_idle) && in_valid;
	assign seed        = (state == st_init);
	assign propagate   = (state == st_propagate) && !sink_reached;
	assign trace_start = (state == st_propagate) && sink_reached;
	// every cell visited by the walk is blocked, source included
	assign block_en    = (state == st_retrace);
	assign trace_step  = (state == st_retrace) && !arrived;
	assign clean       = (state == st_clean);
	// queue pops while the grid is cleaned
	assign next_net    = (state == st_clean);

	// follows the state one edge behind, low in idle and load
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else begin
			busy <= !(next_state inside {st_idle, st_load});
		end
	end

	// ======================================================================
	// wavefront sequence
	// ======================================================================

	// counts up through seed and propagation, then backs off by two when
	// the sink is hit so retrace starts on the code one step before it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seq_cnt <= '0;
		end else begin
			case (state)
				st_init: begin
					seq_cnt <= seq_cnt + 2'd1;
				end
				st_propagate: begin
					seq_cnt <= sink_reached ? seq_cnt - 2'd2 : seq_cnt + 2'd1;
				end
				st_retrace: begin
					if (trace_step) begin
						seq_cnt <= seq_cnt - 2'd1;
					end
				end
				default: begin
					seq_cnt <= '0;
				end
			endcase
		end
	end

	// 0,1 -> two   2,3 -> three
	assign seq_code = seq_cnt[1] ? cell_three : cell_two;

endmodule

`default_nettype wire

/* hdl/net_buffer.sv */
/*
 * net list queue
 * source/sink capture from paired strobes, shift out after each route
 */

`include "mr_defines.svh"

`default_nettype none

module net_buffer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  logic [`MR_GRID_BITS-1:0] loc_x,
	input  logic [`MR_GRID_BITS-1:0] loc_y,
	input  logic                     next_net,
	output mr_pkg::net_t             head,
	output logic                     last_net
);
	import mr_pkg::*;

	net_t queue [`MR_NET_MAX];

	// set once the source of a net is in
	logic                               sink_phase;
	logic [$clog2(`MR_NET_MAX+1)-1:0]   count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sink_phase <= 1'b0;
			count      <= '0;
		end else if (in_valid) begin
			sink_phase <= !sink_phase;
			if (sink_phase) begin
				count <= count + 1'b1;
			end
		end else if (next_net && count != '0) begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			if (!sink_phase) begin
				queue[count].src.x <= loc_x;
				queue[count].src.y <= loc_y;
			end else begin
				queue[count].sink.x <= loc_x;
				queue[count].sink.y <= loc_y;
			end
		end else if (next_net) begin
			for (int i = 0; i < `MR_NET_MAX - 1; i++) begin
				queue[i] <= queue[i+1];
			end
		end
	end

	assign head = queue[0];

	// head is the final net, or nothing is queued
	assign last_net = (count <= 1);

endmodule

`default_nettype wire

/* hdl/grid_map.sv */
/*
 * cell-code grid
 * map row load, source seeding, parallel wavefront expansion,
 * path blocking, clean between nets, sink and neighbor lookup
 */

`include "mr_defines.svh"

`default_nettype none

module grid_map (
	input  logic                     clk,
	input  logic                     map_valid,
	input  logic [`MR_GRID_SIZE-1:0] map_row,
	input  logic                     seed,
	input  logic                     propagate,
	input  logic                     block_en,
	input  logic                     clean,
	input  mr_pkg::cell_t            seq_code,
	input  mr_pkg::net_t             head,
	input  mr_pkg::coord_t           pos,
	output logic                     sink_reached,
	output mr_pkg::neighbors_t       neighbors
);
	import mr_pkg::*;

	// indexed [y][x]
	cell_t grid [`MR_GRID_SIZE][`MR_GRID_SIZE];

	logic                     map_valid_q;
	logic [`MR_GRID_SIZE-1:0] map_row_q;
	logic [`MR_GRID_BITS-1:0] row_cnt;

	// reached flags and their four-neighbor OR, bit [y][x]
	logic [`MR_GRID_SIZE-1:0][`MR_GRID_SIZE-1:0] reached;
	logic [`MR_GRID_SIZE-1:0][`MR_GRID_SIZE-1:0] hit;

	// ======================================================================
	// map load
	// ======================================================================

	// row registered first, written the following cycle
	always_ff @(posedge clk) begin
		map_valid_q <= map_valid && !clean;
		map_row_q   <= map_row;
		if (clean) begin
			row_cnt <= '0;
		end else if (map_valid_q) begin
			row_cnt <= row_cnt + 1'b1;
		end
	end

	// ======================================================================
	// wavefront
	// ======================================================================

	always_comb begin
		for (int y = 0; y < `MR_GRID_SIZE; y++) begin
			for (int x = 0; x < `MR_GRID_SIZE; x++) begin
				reached[y][x] = grid[y][x][1];
			end
		end
	end

	// shifting a packed row drops the off-grid columns
	always_comb begin
		for (int y = 0; y < `MR_GRID_SIZE; y++) begin
			hit[y] = (reached[y] << 1) | (reached[y] >> 1);
			if (y > 0) begin
				hit[y] = hit[y] | reached[y-1];
			end
			if (y < `MR_GRID_SIZE - 1) begin
				hit[y] = hit[y] | reached[y+1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (map_valid_q) begin
			for (int x = 0; x < `MR_GRID_SIZE; x++) begin
				grid[row_cnt][x] <= map_row_q[x] ? cell_blocked : cell_empty;
			end
		end else if (seed) begin
			// sink may be a blocked pin on the map, open it for this net
			grid[head.src.y][head.src.x]   <= seq_code;
			grid[head.sink.y][head.sink.x] <= cell_empty;
		end else if (propagate) begin
			for (int y = 0; y < `MR_GRID_SIZE; y++) begin
				for (int x = 0; x < `MR_GRID_SIZE; x++) begin
					if (grid[y][x] == cell_empty && hit[y][x]) begin
						grid[y][x] <= seq_code;
					end
				end
			end
		end else if (block_en) begin
			grid[pos.y][pos.x] <= cell_blocked;
		end else if (clean) begin
			for (int y = 0; y < `MR_GRID_SIZE; y++) begin
				for (int x = 0; x < `MR_GRID_SIZE; x++) begin
					if (grid[y][x] != cell_blocked) begin
						grid[y][x] <= cell_empty;
					end
				end
			end
		end
	end

	// ======================================================================
	// lookups
	// ======================================================================

	assign sink_reached = reached[head.sink.y][head.sink.x];

	always_comb begin
		neighbors.down  = (pos.y == '1) ? cell_blocked : grid[pos.y + 1'b1][pos.x];
		neighbors.up    = (pos.y == '0) ? cell_blocked : grid[pos.y - 1'b1][pos.x];
		neighbors.right = (pos.x == '1) ? cell_blocked : grid[pos.y][pos.x + 1'b1];
		neighbors.left  = (pos.x == '0) ? cell_blocked : grid[pos.y][pos.x - 1'b1];
	end

endmodule

`default_nettype wire

/* hdl/retrace_unit.sv */
/*
 * retrace walker
 * sink-to-source position stepping and path cost count
 */

`include "mr_defines.svh"

`default_nettype none

module retrace_unit (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     trace_start,
	input  logic                     trace_step,
	input  logic                     job_start,
	input  mr_pkg::cell_t            seq_code,
	input  mr_pkg::neighbors_t       neighbors,
	input  mr_pkg::net_t             head,
	output mr_pkg::coord_t           pos,
	output logic                     arrived,
	output logic [`MR_COST_BITS-1:0] cost
);

	// cell being left lies strictly between the pins
	logic leave_inner;

	assign arrived     = (pos == head.src);
	assign leave_inner = trace_step && !arrived && (pos != head.sink);

	// ======================================================================
	// position walk
	// ======================================================================

	// first match wins in the order down, up, right, left
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos <= '0;
		end else if (trace_start) begin
			pos <= head.sink;
		end else if (trace_step) begin
			if (neighbors.down == seq_code) begin
				pos.y <= pos.y + 1'b1;
			end else if (neighbors.up == seq_code) begin
				pos.y <= pos.y - 1'b1;
			end else if (neighbors.right == seq_code) begin
				pos.x <= pos.x + 1'b1;
			end else if (neighbors.left == seq_code) begin
				pos.x <= pos.x - 1'b1;
			end
		end
	end

	// ======================================================================
	// cost
	// ======================================================================

	// one per path cell, held after the job until the next one starts
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cost <= '0;
		end else if (job_start) begin
			cost <= '0;
		end else if (leave_inner) begin
			cost <= cost + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/maze_router_top.sv */
/*
 * maze router top level
 * controller, net buffer, cell grid and retrace unit
 */

`include "mr_defines.svh"

`default_nettype none

module maze_router_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     map_valid,
	input  logic [`MR_GRID_SIZE-1:0] map_row,
	input  logic                     in_valid,
	input  logic [`MR_GRID_BITS-1:0] loc_x,
	input  logic [`MR_GRID_BITS-1:0] loc_y,
	output logic                     busy,
	output logic [`MR_COST_BITS-1:0] cost
);
	import mr_pkg::*;

	// controller strobes
	logic seed;
	logic propagate;
	logic block_en;
	logic clean;
	logic trace_start;
	logic trace_step;
	logic next_net;
	logic job_start;

	// status back to the controller
	logic sink_reached;
	logic arrived;
	logic last_net;

	cell_t      seq_code;
	net_t       head;
	coord_t     pos;
	neighbors_t neighbors;

	route_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.sink_reached (sink_reached),
		.arrived      (arrived),
		.last_net     (last_net),
		.seed         (seed),
		.propagate    (propagate),
		.block_en     (block_en),
		.clean        (clean),
		.trace_start  (trace_start),
		.trace_step   (trace_step),
		.next_net     (next_net),
		.job_start    (job_start),
		.busy         (busy),
		.seq_code     (seq_code)
	);

	net_buffer u_nets (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.loc_x    (loc_x),
		.loc_y    (loc_y),
		.next_net (next_net),
		.head     (head),
		.last_net (last_net)
	);

	grid_map u_grid (
		.clk          (clk),
		.map_valid    (map_valid),
		.map_row      (map_row),
		.seed         (seed),
		.propagate    (propagate),
		.block_en     (block_en),
		.clean        (clean),
		.seq_code     (seq_code),
		.head         (head),
		.pos          (pos),
		.sink_reached (sink_reached),
		.neighbors    (neighbors)
	);

	retrace_unit u_trace (
		.clk         (clk),
		.rst_n       (rst_n),
		.trace_start (trace_start),
		.trace_step  (trace_step),
		.job_start   (job_start),
		.seq_code    (seq_code),
		.neighbors   (neighbors),
		.head        (head),
		.pos         (pos),
		.arrived     (arrived),
		.cost        (cost)
	);

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
/*
 * free-running testbench clock, 8 ns period
 */

`default_nettype none

module tb_clock (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
	end

	// half period
	always begin
		#4 clk = ~clk;
	end

endmodule

`default_nettype wire

/* testbench/maze_router_tb.sv */
/*
 * maze router testbench
 * job file reader, map and net driver, busy and cost checks, watchdog
 */

`include "mr_defines.svh"

`default_nettype none

module maze_router_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import mr_pkg::*;

	localparam int    MAX_JOBS       = 16;
	localparam int    CYCLES_PER_JOB = 2000;
	localparam int    RESET_CYCLES   = 8;
	localparam string JOB_FILE       = "testbench/route_input.txt";

	logic                     clk;
	logic                     rst_n;
	logic                     map_valid;
	logic [`MR_GRID_SIZE-1:0] map_row;
	logic                     in_valid;
	logic [`MR_GRID_BITS-1:0] loc_x;
	logic [`MR_GRID_BITS-1:0] loc_y;
	logic                     busy;
	logic [`MR_COST_BITS-1:0] cost;

	// jobs as read from the file
	string                    job_name [MAX_JOBS];
	int                       job_nets [MAX_JOBS];
	int                       job_cost [MAX_JOBS];
	int                       job_seen [MAX_JOBS];
	logic [`MR_GRID_SIZE-1:0] job_map  [MAX_JOBS][`MR_GRID_SIZE];
	net_t                     job_net  [MAX_JOBS][`MR_NET_MAX];
	int                       job_count;
	logic                     jobs_loaded;

	int error_count;
	int test_count;
	int failed_tests;

	tb_clock u_clock (
		.clk (clk)
	);

	maze_router_top maze_router_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.map_valid (map_valid),
		.map_row   (map_row),
		.in_valid  (in_valid),
		.loc_x     (loc_x),
		.loc_y     (loc_y),
		.busy      (busy),
		.cost      (cost)
	);

	// ======================================================================
	// job file
	// ======================================================================

	// lines are tagged job, map or net and # starts a comment
	task automatic read_jobs(output bit ok);
		int    fd;
		int    n;
		int    cur;
		int    sx;
		int    sy;
		int    kx;
		int    ky;
		string line;
		string tag;
		string name;

		ok        = 1'b1;
		cur       = -1;
		job_count = 0;
		fd = $fopen(JOB_FILE, "r");
		if (fd == 0) begin
			$display("cannot open job file %s", JOB_FILE);
			ok = 1'b0;
			return;
		end
		while (ok && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%s", tag);
			if (n < 1 || tag.getc(0) == "#") begin
				continue;
			end
			if (tag == "job" && job_count < MAX_JOBS) begin
				cur = job_count;
				job_count++;
				job_seen[cur] = 0;
				n = $sscanf(line, "%s %s %d %d", tag, name, job_nets[cur], job_cost[cur]);
				job_name[cur] = name;
				if (n != 4 || job_nets[cur] < 1 || job_nets[cur] > `MR_NET_MAX) begin
					$display("job line is malformed: %s", line);
					ok = 1'b0;
				end
			end else if (tag == "map" && cur >= 0) begin
				n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", tag,
					job_map[cur][0], job_map[cur][1], job_map[cur][2], job_map[cur][3],
					job_map[cur][4], job_map[cur][5], job_map[cur][6], job_map[cur][7],
					job_map[cur][8], job_map[cur][9], job_map[cur][10], job_map[cur][11],
					job_map[cur][12], job_map[cur][13], job_map[cur][14], job_map[cur][15]);
				if (n != `MR_GRID_SIZE + 1) begin
					$display("map line does not hold %0d rows: %s", `MR_GRID_SIZE, line);
					ok = 1'b0;
				end
			end else if (tag == "net" && cur >= 0 && job_seen[cur] < `MR_NET_MAX) begin
				n = $sscanf(line, "%s %d %d %d %d", tag, sx, sy, kx, ky);
				if (n != 5) begin
					$display("net line is malformed: %s", line);
					ok = 1'b0;
				end else begin
					job_net[cur][job_seen[cur]].src.x  = sx[`MR_GRID_BITS-1:0];
					job_net[cur][job_seen[cur]].src.y  = sy[`MR_GRID_BITS-1:0];
					job_net[cur][job_seen[cur]].sink.x = kx[`MR_GRID_BITS-1:0];
					job_net[cur][job_seen[cur]].sink.y = ky[`MR_GRID_BITS-1:0];
					job_seen[cur]++;
				end
			end else begin
				$display("unexpected or excess line in job file: %s", line);
				ok = 1'b0;
			end
		end
		$fclose(fd);
		// each job needs its full net list
		for (int j = 0; j < job_count; j++) begin
			if (job_seen[j] != job_nets[j]) begin
				$display("job %s lists %0d nets but declares %0d", job_name[j],
					job_seen[j], job_nets[j]);
				ok = 1'b0;
			end
		end
		if (job_count == 0) begin
			$display("job file holds no jobs");
			ok = 1'b0;
		end
	endtask

	// ======================================================================
	// tests
	// ======================================================================

	task automatic report_test(input string name, input int errs);
		test_count++;
		if (errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d error(s)", name, errs);
			failed_tests++;
			error_count += errs;
		end
	endtask

	// outputs idle after reset while inputs are still at rest
	task automatic check_reset_state();
		int errs;

		errs = 0;
		repeat (2) @(negedge clk);
		if (busy !== 1'b0) begin
			$display("MISMATCH reset_state busy: expected 0, actual %b", busy);
			errs++;
		end
		if (cost !== '0) begin
			$display("MISMATCH reset_state cost: expected 0, actual %0d", cost);
			errs++;
		end
		report_test("reset_state", errs);
	endtask

	task automatic run_job(input int j, input logic [`MR_COST_BITS-1:0] held);
		int                       errs;
		int                       rise_wait;
		logic [`MR_COST_BITS-1:0] expected;

		errs     = 0;
		expected = job_cost[j][`MR_COST_BITS-1:0];

		// map rows go in row 0 first at one row per cycle
		for (int r = 0; r < `MR_GRID_SIZE; r++) begin
			map_valid = 1'b1;
			map_row   = job_map[j][r];
			@(negedge clk);
		end
		map_valid = 1'b0;
		map_row   = '0;

		// previous result stays on cost until the first in_valid
		if (cost !== held) begin
			$display("MISMATCH %s cost hold: expected %0d, actual %0d",
				job_name[j], held, cost);
			errs++;
		end

		// source then sink for every net on unbroken in_valid cycles
		for (int n = 0; n < job_nets[j]; n++) begin
			in_valid = 1'b1;
			loc_x    = job_net[j][n].src.x;
			loc_y    = job_net[j][n].src.y;
			@(negedge clk);
			// cost drops to zero on the first in_valid of a job
			if (n == 0 && cost !== '0) begin
				$display("MISMATCH %s cost clear: expected 0, actual %0d",
					job_name[j], cost);
				errs++;
			end
			loc_x = job_net[j][n].sink.x;
			loc_y = job_net[j][n].sink.y;
			@(negedge clk);
		end
		in_valid = 1'b0;
		loc_x    = '0;
		loc_y    = '0;

		rise_wait = 0;
		while (!busy && rise_wait < 2) begin
			@(negedge clk);
			rise_wait++;
		end
		if (!busy) begin
			$display("test %s: busy did not rise within two cycles after the last net",
				job_name[j]);
			errs++;
		end else begin
			while (busy) begin
				@(negedge clk);
			end
			if (cost !== expected) begin
				$display("MISMATCH %s cost: expected %0d, actual %0d",
					job_name[j], expected, cost);
				errs++;
			end
		end
		report_test(job_name[j], errs);
	endtask

	// ======================================================================
	// main flow and watchdog
	// ======================================================================

	initial begin : main_flow
		bit                       files_ok;
		int                       gap;
		logic [`MR_COST_BITS-1:0] held;

		rst_n        = 1'b0;
		map_valid    = 1'b0;
		map_row      = '0;
		in_valid     = 1'b0;
		loc_x        = '0;
		loc_y        = '0;
		error_count  = 0;
		test_count   = 0;
		failed_tests = 0;
		jobs_loaded  = 1'b0;
		void'($urandom(11));
		read_jobs(files_ok);
		if (!files_ok) begin
			$display("Checks failed");
			$finish;
		end else begin
			jobs_loaded = 1'b1;
			repeat (RESET_CYCLES) @(negedge clk);
			rst_n = 1'b1;
			check_reset_state();
			for (int j = 0; j < job_count; j++) begin
				// idle gap of 0 to 3 cycles
				gap = $urandom % 4;
				repeat (gap) @(negedge clk);
				if (j == 0) begin
					held = '0;
				end else begin
					held = job_cost[j-1][`MR_COST_BITS-1:0];
				end
				run_job(j, held);
			end
			$display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests,
				error_count);
			if (error_count == 0 && failed_tests == 0) begin
				$display("All checks passed");
			end else begin
				$display("Checks failed");
			end
			$finish;
		end
	end

	// budget grows with the number of jobs in the file
	initial begin : watchdog
		int limit;

		wait (jobs_loaded === 1'b1);
		limit = RESET_CYCLES + (job_count + 1) * CYCLES_PER_JOB;
		repeat (limit) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/route_input.txt */
# job <name> <net count> <expected cost>, then map <16 hex rows, row 0 first, bit n = column n>
# then one line per net: net <source x> <source y> <sink x> <sink y>

job open_single 1 12
map 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
net 1 2 9 7

job wall_gap 1 36
map 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0000
net 2 2 13 2

# second net detours to the right, third net goes over the top of it
job three_nets 3 39
map 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
net 2 5 10 5
net 6 2 6 8
net 13 4 9 4

job row_gap 1 31
map 0000 0000 0000 0000 0000 0000 0000 0000 7fff 0000 0000 0000 0000 0000 0000 0000
net 3 4 3 12

job corner 1 29
map 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
net 0 0 15 15

/* flist.f */
+incdir+hdl
hdl/mr_pkg.sv
hdl/route_ctrl.sv
hdl/net_buffer.sv
hdl/grid_map.sv
hdl/retrace_unit.sv
hdl/maze_router_top.sv
testbench/tb_clock.sv
testbench/maze_router_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the maze router testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f flist.f --top-module maze_router_tb \
	-o maze_router_sim || exit 1
out=$(./obj_dir/maze_router_sim)
echo "$out"
echo "$out" | grep -qx "All checks passed" && exit 0 || exit 1
